// File: list.f
io_cmd_pkg.sv
ps2_pkg.sv
spi_shifter.sv
spi_sys_sync.sv
io_regs.sv
kbd_decoder.sv
ps2_kbd_tx.sv
mist_user_io.sv
tb_mist_user_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_mist_user_io -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Testbench passed" sim.log; then
	exit 0
else
	exit 1
fi

// File: tb_mist_user_io.sv
// testbench for the board controller link
// drives SPI frames and checks registers, key events, PS/2 frames and MISO replies
`timescale 1ns/1ns
`default_nettype none

module tb_mist_user_io;
	import io_cmd_pkg::*;

	localparam int PS2_DIV_TB  = 10;
	localparam int IDLE_MARGIN = 20;
	// 29 bytes in 7 frames, each bit 4 cycles, plus frame edges and idle margin
	localparam int SPI_CYCLES  = 29 * 32 + 7 * (IDLE_MARGIN + 4);
	// 4 PS/2 frames of 11 bits plus one bit period of start delay each
	localparam int PS2_CYCLES  = 4 * 12 * 2 * (PS2_DIV_TB + 1);
	localparam int CYCLE_LIMIT = (3 * (3 + SPI_CYCLES + PS2_CYCLES)) / 2;

	logic       clk_sys = 1'b0;
	logic       SPI_CLK;
	logic       SPI_SS_IO;
	logic       SPI_MOSI;
	byte_t      leds_i;
	wire        SPI_MISO;
	logic [1:0] buttons_o;
	logic [1:0] switches_o;
	logic       scandoubler_disable_o;
	logic       ypbpr_o;
	logic       no_csync_o;
	joy_t       joystick_0_o;
	joy_t       joystick_1_o;
	status_t    status_o;
	logic       key_pressed_o;
	logic       key_extended_o;
	byte_t      key_code_o;
	logic       key_strobe_o;
	logic       ps2_kbd_clk_o;
	logic       ps2_kbd_data_o;

	byte_t      tx_bytes [$];
	byte_t      rx_bytes [$];
	logic [9:0] key_q [$];
	byte_t      ps2_q [$];
	logic [31:0] lfsr_state = 32'h97c3b2e3;
	int         cycle_cnt = 0;
	byte_t      code1;
	byte_t      code2;
	joy_t       joy0_before;
	joy_t       exp_joy;
	status_t    exp_status;
	byte_t      exp_ps2 [4];
	logic       ps2_start;
	logic       ps2_par;
	logic       ps2_stop;
	byte_t      ps2_byte;

	mist_user_io #(.PS2_DIV(PS2_DIV_TB)) dut0 (
		.clk_sys(clk_sys), .SPI_CLK(SPI_CLK), .SPI_SS_IO(SPI_SS_IO), .SPI_MOSI(SPI_MOSI),
		.leds_i(leds_i), .SPI_MISO(SPI_MISO), .buttons_o(buttons_o),
		.switches_o(switches_o), .scandoubler_disable_o(scandoubler_disable_o),
		.ypbpr_o(ypbpr_o), .no_csync_o(no_csync_o), .joystick_0_o(joystick_0_o),
		.joystick_1_o(joystick_1_o), .status_o(status_o), .key_pressed_o(key_pressed_o),
		.key_extended_o(key_extended_o), .key_code_o(key_code_o),
		.key_strobe_o(key_strobe_o), .ps2_kbd_clk_o(ps2_kbd_clk_o),
		.ps2_kbd_data_o(ps2_kbd_data_o)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run did not finish within %0d clk_sys cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		$display("error %s: expected %h, actual %h", name, exp, act);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// advance n cycles, ending 1 ns after the rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	task automatic build_frame(input byte_t cmd, input int n);
		byte_t b;
		tx_bytes.delete();
		tx_bytes.push_back(cmd);
		repeat (n) begin
			rand_byte(b);
			tx_bytes.push_back(b);
		end
	endtask

	// MISO is sampled just before each rising SPI clock
	task automatic send_frame();
		byte_t tx;
		byte_t rx;
		byte_t exp_reply;
		rx_bytes.delete();
		SPI_SS_IO = 1'b0;
		tick(2);
		foreach (tx_bytes[i]) begin
			tx = tx_bytes[i];
			for (int b = 7; b >= 0; b--) begin
				SPI_MOSI = tx[b];
				tick(2);
				rx = {rx[6:0], SPI_MISO};
				SPI_CLK = 1'b1;
				tick(2);
				SPI_CLK = 1'b0;
			end
			rx_bytes.push_back(rx);
		end
		tick(2);
		SPI_SS_IO = 1'b1;
		tick(IDLE_MARGIN);
		assert (rx_bytes[0] == CORE_TYPE)
			else report_mismatch("miso core type", CORE_TYPE, rx_bytes[0]);
		exp_reply = (tx_bytes[0] == CMD_LEDS) ? leds_i : 8'h00;
		for (int i = 1; i < rx_bytes.size(); i++) begin
			assert (rx_bytes[i] == exp_reply)
				else report_mismatch("miso reply byte", exp_reply, rx_bytes[i]);
		end
	endtask

	always @(negedge clk_sys) begin
		if (key_strobe_o)
			key_q.push_back({key_pressed_o, key_extended_o, key_code_o});
	end

	// PS/2 frame monitor
	// the device drives data while the clock is high
	always begin
		@(negedge ps2_kbd_clk_o);
		ps2_start = ps2_kbd_data_o;
		for (int i = 0; i < 8; i++) begin
			@(negedge ps2_kbd_clk_o);
			ps2_byte[i] = ps2_kbd_data_o;
		end
		@(negedge ps2_kbd_clk_o);
		ps2_par = ps2_kbd_data_o;
		@(negedge ps2_kbd_clk_o);
		ps2_stop = ps2_kbd_data_o;
		assert (ps2_start == 1'b0) else report_mismatch("ps2 start bit", 0, ps2_start);
		assert (^{ps2_byte, ps2_par} == 1'b1)
			else report_mismatch("ps2 odd parity", 1, ^{ps2_byte, ps2_par});
		assert (ps2_stop == 1'b1) else report_mismatch("ps2 stop bit", 1, ps2_stop);
		ps2_q.push_back(ps2_byte);
	end

	initial begin
		SPI_CLK   = 1'b0;
		SPI_SS_IO = 1'b1;
		SPI_MOSI  = 1'b0;
		// nonzero so that zero replies differ from the LED byte
		leds_i    = 8'h5a;
		tick(3);
		assert ({ps2_kbd_clk_o, ps2_kbd_data_o, key_strobe_o} == 3'b110)
			else report_mismatch("after reset", 3'b110,
				{ps2_kbd_clk_o, ps2_kbd_data_o, key_strobe_o});

		// buttons and switches
		build_frame(CMD_BUT_SW, 1);
		send_frame();
		assert ({no_csync_o, ypbpr_o, scandoubler_disable_o, switches_o, buttons_o}
				== tx_bytes[1][6:0])
			else report_mismatch("buttons", tx_bytes[1][6:0], {no_csync_o, ypbpr_o,
				scandoubler_disable_o, switches_o, buttons_o});

		// fifth joystick byte is ignored
		joy0_before = joystick_0_o;
		build_frame(CMD_JOY_BASE + 8'd1, 5);
		send_frame();
		exp_joy = {tx_bytes[4], tx_bytes[3], tx_bytes[2], tx_bytes[1]};
		assert (joystick_1_o == exp_joy) else report_mismatch("joystick 1", exp_joy, joystick_1_o);
		assert (joystick_0_o == joy0_before)
			else report_mismatch("joystick 0", joy0_before, joystick_0_o);

		build_frame(CMD_STATUS64, 8);
		send_frame();
		for (int i = 1; i <= 8; i++)
			exp_status[(i - 1) * 8 +: 8] = tx_bytes[i];
		assert (status_o == exp_status) else report_mismatch("status64", exp_status, status_o);
		build_frame(CMD_STATUS8, 1);
		send_frame();
		exp_status[7:0] = tx_bytes[1];
		assert (status_o == exp_status) else report_mismatch("status8", exp_status, status_o);

		// key codes must not look like a prefix byte
		rand_byte(code1);
		rand_byte(code2);
		if (code1 == 8'he0 || code1 == 8'hf0)
			code1 = code1 ^ 8'h01;
		if (code2 == 8'he0 || code2 == 8'hf0)
			code2 = code2 ^ 8'h01;
		tx_bytes.delete();
		tx_bytes.push_back(CMD_KBD);
		tx_bytes.push_back(8'he0);
		tx_bytes.push_back(8'hf0);
		tx_bytes.push_back(code1);
		send_frame();
		tx_bytes.delete();
		tx_bytes.push_back(CMD_KBD);
		tx_bytes.push_back(code2);
		send_frame();
		assert (key_q.size() == 2) else report_mismatch("key event count", 2, key_q.size());
		assert (key_q[0] == {1'b0, 1'b1, code1})
			else report_mismatch("key event 0", {1'b0, 1'b1, code1}, key_q[0]);
		assert (key_q[1] == {1'b1, 1'b0, code2})
			else report_mismatch("key event 1", {1'b1, 1'b0, code2}, key_q[1]);

		// wait for all four PS/2 frames, then one bit period for idle
		while (ps2_q.size() < 4)
			tick(1);
		tick(2 * (PS2_DIV_TB + 1) + 2);
		exp_ps2 = '{8'he0, 8'hf0, code1, code2};
		assert (ps2_q.size() == 4) else report_mismatch("ps2 frame count", 4, ps2_q.size());
		foreach (exp_ps2[i]) begin
			assert (ps2_q[i] == exp_ps2[i]) else report_mismatch("ps2 data", exp_ps2[i], ps2_q[i]);
		end
		assert (ps2_kbd_clk_o == 1'b1) else report_mismatch("ps2 idle clock", 1, ps2_kbd_clk_o);

		rand_byte(leds_i);
		if (leds_i == 8'h00)
			leds_i = 8'h01;
		build_frame(CMD_LEDS, 3);
		send_frame();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mist_user_io.sv
// system clock side of the board controller link
// an SPI front end feeds the register decoder and the keyboard decoder with its PS/2 port
`timescale 1ns/1ns
`default_nettype none

module mist_user_io #(
	parameter int JOY_COUNT     = 2,
	parameter int PS2_DIV       = ps2_pkg::PS2_DIV,
	parameter int PS2_FIFO_BITS = ps2_pkg::PS2_FIFO_BITS
) (
	input  logic                clk_sys,
	input  logic                SPI_CLK,
	input  logic                SPI_SS_IO,
	input  logic                SPI_MOSI,
	input  io_cmd_pkg::byte_t   leds_i,
	output logic                SPI_MISO,
	output logic [1:0]          buttons_o,
	output logic [1:0]          switches_o,
	output logic                scandoubler_disable_o,
	output logic                ypbpr_o,
	output logic                no_csync_o,
	output io_cmd_pkg::joy_t    joystick_0_o,
	output io_cmd_pkg::joy_t    joystick_1_o,
	output io_cmd_pkg::status_t status_o,
	output logic                key_pressed_o,
	output logic                key_extended_o,
	output io_cmd_pkg::byte_t   key_code_o,
	output logic                key_strobe_o,
	output logic                ps2_kbd_clk_o,
	output logic                ps2_kbd_data_o
);
	import io_cmd_pkg::*;
	import ps2_pkg::*;

	byte_t      spi_data;
	logic       byte_tgl;
	logic       in_frame;
	logic       rx_valid;
	rx_byte_s   rx;
	io_ctrl_s   io_ctrl;
	joy_t       joystick [JOY_COUNT];
	key_event_s key;
	logic       push;
	byte_t      push_data;
	logic       fifo_ok;

	spi_shifter u_shifter (
		.spi_clk_i(SPI_CLK), .spi_ss_io_i(SPI_SS_IO), .spi_mosi_i(SPI_MOSI),
		.leds_i(leds_i), .spi_miso_o(SPI_MISO), .rx_data_o(spi_data),
		.byte_tgl_o(byte_tgl), .in_frame_o(in_frame)
	);

	spi_sys_sync u_sync (
		.clk_sys(clk_sys), .spi_ss_io_i(SPI_SS_IO), .rx_data_i(spi_data),
		.byte_tgl_i(byte_tgl), .in_frame_i(in_frame), .rx_valid_o(rx_valid), .rx_o(rx)
	);

	io_regs #(.JOY_COUNT(JOY_COUNT)) u_regs (
		.clk_sys(clk_sys), .rx_valid_i(rx_valid), .rx_i(rx),
		.io_ctrl_o(io_ctrl), .joystick_o(joystick), .status_o(status_o)
	);

	kbd_decoder u_kbd (
		.clk_sys(clk_sys), .rx_valid_i(rx_valid), .rx_i(rx), .fifo_ok_i(fifo_ok),
		.key_o(key), .key_strobe_o(key_strobe_o), .push_o(push), .push_data_o(push_data)
	);

	ps2_kbd_tx #(.PS2_DIV(PS2_DIV), .PS2_FIFO_BITS(PS2_FIFO_BITS)) u_ps2 (
		.clk_sys(clk_sys), .push_i(push), .push_data_i(push_data), .fifo_ok_o(fifo_ok),
		.ps2_clk_o(ps2_kbd_clk_o), .ps2_data_o(ps2_kbd_data_o)
	);

	assign buttons_o             = io_ctrl.buttons;
	assign switches_o            = io_ctrl.switches;
	assign scandoubler_disable_o = io_ctrl.scandoubler_disable;
	assign ypbpr_o               = io_ctrl.ypbpr;
	assign no_csync_o            = io_ctrl.no_csync;
	assign joystick_0_o          = joystick[0];
	assign joystick_1_o          = joystick[1];
	assign key_pressed_o         = key.pressed;
	assign key_extended_o        = key.extended;
	assign key_code_o            = key.code;

endmodule

`default_nettype wire

// File: ps2_kbd_tx.sv
// transmit-only PS/2 keyboard port with a byte FIFO, its own clock
// divider and a start, data, parity, stop frame machine
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_tx #(
	parameter int PS2_DIV       = ps2_pkg::PS2_DIV,
	parameter int PS2_FIFO_BITS = ps2_pkg::PS2_FIFO_BITS
) (
	input  logic              clk_sys,
	input  logic              push_i,
	input  io_cmd_pkg::byte_t push_data_i,
	output logic              fifo_ok_o,
	output logic              ps2_clk_o,
	output logic              ps2_data_o
);
	import io_cmd_pkg::*;
	import ps2_pkg::*;

	localparam int DEPTH = 2 ** PS2_FIFO_BITS;
	localparam int DIV_W = $clog2(PS2_DIV + 1);
	// longest keyboard frame is e0 f0 code
	localparam int FRAME_ROOM = 4;

	logic [DIV_W-1:0]       div_cnt = '0;
	logic                   ps2_clk_r = 1'b0;
	logic                   clk_rise;
	byte_t                  fifo_mem [DEPTH];
	logic [PS2_FIFO_BITS:0] wptr = '0;
	logic [PS2_FIFO_BITS:0] rptr = '0;
	logic [PS2_FIFO_BITS:0] free;
	ps2_tx_state_e          state = TX_IDLE;
	byte_t                  shreg;
	logic [2:0]             bit_cnt;
	logic                   parity;
	logic                   data_r = 1'b1;

	always_ff @(posedge clk_sys) begin
		if (div_cnt == DIV_W'(PS2_DIV)) begin
			div_cnt   <= '0;
			ps2_clk_r <= ~ps2_clk_r;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign clk_rise = (div_cnt == DIV_W'(PS2_DIV)) && !ps2_clk_r;

	assign free      = (PS2_FIFO_BITS + 1)'(DEPTH) - (wptr - rptr);
	assign fifo_ok_o = free >= (PS2_FIFO_BITS + 1)'(FRAME_ROOM);

	always_ff @(posedge clk_sys) begin
		if (push_i && free != '0) begin
			fifo_mem[wptr[PS2_FIFO_BITS-1:0]] <= push_data_i;
			wptr <= wptr + 1'b1;
		end
	end

	// everything moves with the rising PS/2 clock
	always_ff @(posedge clk_sys) begin
		if (clk_rise) begin
			case (state)
				TX_IDLE: begin
					data_r <= 1'b1;
					if (wptr != rptr) begin
						shreg  <= fifo_mem[rptr[PS2_FIFO_BITS-1:0]];
						rptr   <= rptr + 1'b1;
						parity <= 1'b1;
						data_r <= 1'b0;
						state  <= TX_START;
					end
				end
				TX_START, TX_DATA: begin
					if (state == TX_DATA && bit_cnt == '0) begin
						data_r <= parity;
						state  <= TX_PARITY;
					end else begin
						data_r  <= shreg[0];
						shreg   <= {1'b0, shreg[7:1]};
						parity  <= parity ^ shreg[0];
						bit_cnt <= (state == TX_START) ? 3'd1 : bit_cnt + 3'd1;
						state   <= TX_DATA;
					end
				end
				TX_PARITY: begin
					data_r <= 1'b1;
					state  <= TX_STOP;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	assign ps2_clk_o  = ps2_clk_r || (state == TX_IDLE);
	assign ps2_data_o = data_r;

endmodule

`default_nettype wire

// File: kbd_decoder.sv
// keyboard frame decoder, turns scan code sequences into key events
// and forwards the raw bytes of accepted frames to the PS/2 FIFO
`timescale 1ns/1ns
`default_nettype none

module kbd_decoder (
	input  logic                   clk_sys,
	input  logic                   rx_valid_i,
	input  io_cmd_pkg::rx_byte_s   rx_i,
	input  logic                   fifo_ok_i,
	output ps2_pkg::key_event_s    key_o,
	output logic                   key_strobe_o,
	output logic                   push_o,
	output io_cmd_pkg::byte_t      push_data_o
);
	import io_cmd_pkg::*;
	import ps2_pkg::*;

	localparam byte_t KEY_EXT   = 8'he0;
	localparam byte_t KEY_BREAK = 8'hf0;

	logic       kbd_byte;
	logic       accept_r = 1'b0;
	logic       ext_r = 1'b0;
	logic       pressed_r = 1'b1;
	logic       ext_cur;
	logic       pressed_cur;
	key_event_s key_r = '0;
	logic       strobe_r = 1'b0;
	logic       push_r = 1'b0;
	byte_t      push_data_r;

	assign kbd_byte = rx_valid_i && rx_i.cmd == CMD_KBD && rx_i.idx != '0;

	// prefix flags start over with the first data byte
	assign ext_cur     = (rx_i.idx == 4'd1) ? 1'b0 : ext_r;
	assign pressed_cur = (rx_i.idx == 4'd1) ? 1'b1 : pressed_r;

	always_ff @(posedge clk_sys) begin
		strobe_r <= 1'b0;
		push_r   <= 1'b0;
		// room for the whole frame is decided on the command byte
		if (rx_valid_i && rx_i.idx == '0)
			accept_r <= (rx_i.data == CMD_KBD) && fifo_ok_i;
		if (kbd_byte) begin
			push_r      <= accept_r;
			push_data_r <= rx_i.data;
			ext_r       <= ext_cur;
			pressed_r   <= pressed_cur;
			if (rx_i.data == KEY_EXT) begin
				ext_r <= 1'b1;
			end else if (rx_i.data == KEY_BREAK) begin
				pressed_r <= 1'b0;
			end else begin
				key_r    <= '{pressed: pressed_cur, extended: ext_cur, code: rx_i.data};
				strobe_r <= 1'b1;
			end
		end
	end

	assign key_o        = key_r;
	assign key_strobe_o = strobe_r;
	assign push_o       = push_r;
	assign push_data_o  = push_data_r;

endmodule

`default_nettype wire

// File: io_regs.sv
// register decoder for buttons, digital joysticks and the status word
`timescale 1ns/1ns
`default_nettype none

module io_regs #(
	parameter int JOY_COUNT = 2
) (
	input  logic                 clk_sys,
	input  logic                 rx_valid_i,
	input  io_cmd_pkg::rx_byte_s rx_i,
	output io_cmd_pkg::io_ctrl_s io_ctrl_o,
	output io_cmd_pkg::joy_t     joystick_o [JOY_COUNT],
	output io_cmd_pkg::status_t  status_o
);
	import io_cmd_pkg::*;

	io_ctrl_s  io_ctrl_r = '0;
	joy_t      joy_r [JOY_COUNT] = '{default: '0};
	status_t   status_r = '0;
	logic      data_byte;
	byte_idx_t slot;

	// only bytes after the command carry register data
	assign data_byte = rx_valid_i && (rx_i.idx != '0);
	// byte 1 goes to the least significant lane
	assign slot = rx_i.idx - 4'd1;

	always_ff @(posedge clk_sys) begin
		if (data_byte) begin
			if (rx_i.cmd == CMD_BUT_SW && rx_i.idx == 4'd1)
				io_ctrl_r <= io_ctrl_s'(rx_i.data[6:0]);

			if (rx_i.cmd == CMD_STATUS8 && rx_i.idx == 4'd1)
				status_r[7:0] <= rx_i.data;

			if (rx_i.cmd == CMD_STATUS64 && rx_i.idx <= 4'd8)
				status_r[{slot[2:0], 3'b000} +: 8] <= rx_i.data;

			// bytes past the fourth are dropped
			for (int n = 0; n < JOY_COUNT; n++) begin
				if (rx_i.cmd == cmd_t'(CMD_JOY_BASE + n) && rx_i.idx <= 4'd4)
					joy_r[n][{slot[1:0], 3'b000} +: 8] <= rx_i.data;
			end
		end
	end

	assign io_ctrl_o  = io_ctrl_r;
	assign joystick_o = joy_r;
	assign status_o   = status_r;

endmodule

`default_nettype wire

// File: spi_sys_sync.sv
// moves received SPI bytes into clk_sys and tags each one with
// its position in the frame and the frame's command byte
`timescale 1ns/1ns
`default_nettype none

module spi_sys_sync (
	input  logic                 clk_sys,
	input  logic                 spi_ss_io_i,
	input  io_cmd_pkg::byte_t    rx_data_i,
	input  logic                 byte_tgl_i,
	input  logic                 in_frame_i,
	output logic                 rx_valid_o,
	output io_cmd_pkg::rx_byte_s rx_o
);
	import io_cmd_pkg::*;

	logic [1:0] frame_q;
	logic [2:0] tgl_q = '0;
	logic       rx_valid;
	byte_idx_t  idx_r = '0;
	cmd_t       cmd_r;

	always_ff @(posedge clk_sys or posedge spi_ss_io_i) begin
		if (spi_ss_io_i)
			frame_q <= '0;
		else
			frame_q <= {frame_q[0], in_frame_i};
	end

	always_ff @(posedge clk_sys)
		tgl_q <= {tgl_q[1:0], byte_tgl_i};

	// rx_data_i has been stable since before the toggle changed
	assign rx_valid = tgl_q[1] ^ tgl_q[2];

	// a byte still in flight at frame end wins over the index clear
	always_ff @(posedge clk_sys) begin
		if (rx_valid) begin
			if (idx_r != '1)
				idx_r <= idx_r + 4'd1;
			if (idx_r == '0)
				cmd_r <= rx_data_i;
		end else if (!frame_q[1]) begin
			idx_r <= '0;
		end
	end

	assign rx_valid_o = rx_valid;
	assign rx_o = '{
		data: rx_data_i,
		idx:  idx_r,
		cmd:  (idx_r == '0) ? rx_data_i : cmd_r
	};

endmodule

`default_nettype wire

// File: spi_shifter.sv
// SPI shifter in the SPI clock domain
// assembles MOSI bytes and shifts the reply byte out on MISO
`timescale 1ns/1ns
`default_nettype none

module spi_shifter (
	input  logic              spi_clk_i,
	input  logic              spi_ss_io_i,
	input  logic              spi_mosi_i,
	input  io_cmd_pkg::byte_t leds_i,
	output logic              spi_miso_o,
	output io_cmd_pkg::byte_t rx_data_o,
	output logic              byte_tgl_o,
	output logic              in_frame_o
);
	import io_cmd_pkg::*;

	logic [2:0] bit_cnt;
	byte_idx_t  byte_cnt;
	logic [6:0] sbuf;
	cmd_t       cmd_r;
	cmd_t       cur_cmd;
	byte_t      reply_r;
	logic       miso_r;
	// flips once per byte, carried across frame ends
	logic       tgl_r = 1'b0;

	// during byte 0 the command is still in the shifter
	assign cur_cmd = (byte_cnt == '0) ? {sbuf, spi_mosi_i} : cmd_r;

	always_ff @(posedge spi_clk_i or posedge spi_ss_io_i) begin
		if (spi_ss_io_i) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
			cmd_r    <= '0;
			reply_r  <= CORE_TYPE;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (byte_cnt != '1)
					byte_cnt <= byte_cnt + 4'd1;
				cmd_r <= cur_cmd;
				// next reply byte
				reply_r <= (cur_cmd == CMD_LEDS) ? leds_i : '0;
			end
		end
	end

	always_ff @(posedge spi_clk_i) begin
		if (bit_cnt == 3'd7) begin
			rx_data_o <= {sbuf, spi_mosi_i};
			tgl_r     <= ~tgl_r;
		end else begin
			sbuf <= {sbuf[5:0], spi_mosi_i};
		end
	end

	// MSB of the core type is ready before the first rising edge
	always_ff @(negedge spi_clk_i or posedge spi_ss_io_i) begin
		if (spi_ss_io_i)
			miso_r <= CORE_TYPE[7];
		else
			miso_r <= reply_r[~bit_cnt];
	end

	assign spi_miso_o = spi_ss_io_i ? 1'bz : miso_r;
	assign byte_tgl_o = tgl_r;
	assign in_frame_o = ~spi_ss_io_i;

endmodule

`default_nettype wire

// File: ps2_pkg.sv
// PS/2 keyboard path definitions: transmit states, key events and
// the default FIFO depth and clock divider
`default_nettype none

package ps2_pkg;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

	// pressed is 0 for a break code
	typedef struct packed {
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_s;

	// 16 byte FIFO
	localparam int PS2_FIFO_BITS = 4;
	// PS/2 clock half period is PS2_DIV+1 clk_sys cycles
	localparam int PS2_DIV = 100;

endpackage

`default_nettype wire

// File: io_cmd_pkg.sv
// command codes, link types and SPI-side structs shared by the
// SPI front end and the register and keyboard decoders
`default_nettype none

package io_cmd_pkg;

	typedef logic [7:0] byte_t;
	// position of a byte within a frame, saturating at 15
	typedef logic [3:0] byte_idx_t;
	typedef logic [7:0] cmd_t;

	localparam cmd_t CMD_BUT_SW   = 8'h01;
	localparam cmd_t CMD_KBD      = 8'h05;
	localparam cmd_t CMD_STATUS8  = 8'h15;
	localparam cmd_t CMD_STATUS64 = 8'h1e;
	localparam cmd_t CMD_LEDS     = 8'h1f;
	// one command per joystick from here up
	localparam cmd_t CMD_JOY_BASE = 8'h60;

	// first reply byte of every frame
	localparam byte_t CORE_TYPE = 8'ha4;

	// one received byte, tagged with its frame position and command
	typedef struct packed {
		byte_t     data;
		byte_idx_t idx;
		cmd_t      cmd;
	} rx_byte_s;

	// layout of the button byte, MSB first
	typedef struct packed {
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} io_ctrl_s;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

endpackage

`default_nettype wire
